// ==== hw/matmul_defs.svh ====
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// element width and grid dimension
`define MM_DWIDTH      8
`define MM_SIZE        4

// operand and result memories
`define MM_AWIDTH      7
`define MM_MEM_DEPTH   128
// engine address outside the fetch window, also marks an empty fetch slot
`define MM_IDLE_ADDR   127

// run schedule in counter values
// done count is 4*size-2+4
`define MM_DONE_CYCLE  18
// grid row r is captured at this count plus r
`define MM_DRAIN_CYCLE 11

`endif

// ==== hw/matmul_pkg.sv ====
`include "matmul_defs.svh"
`default_nettype none

package matmul_pkg;

  // one matrix element, products and sums wrap at this width
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // one memory word, lane 0 sits in the low bits
  typedef elem_t [`MM_SIZE-1:0] row_t;

  // full grid of elements, indexed [row][column]
  typedef row_t [`MM_SIZE-1:0] grid_t;

  // memory address
  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // run cycle count
  typedef logic [15:0] cnt_t;

endpackage

`default_nettype wire

// ==== hw/matmul_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface matmul_ctrl_if;
  import matmul_pkg::*;

  // operand fetch addresses
  addr_t a_addr;
  addr_t b_addr;

  // result write port
  addr_t c_addr;
  logic  c_we;

  // engine owns the memories while high
  logic  busy;

  modport sequencer (
    output a_addr, b_addr, c_addr, c_we, busy
  );

  modport store (
    input a_addr, b_addr, c_addr, c_we, busy
  );

endinterface

`default_nettype wire

// ==== hw/matrix_ram.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module matrix_ram (
  input  logic              clk,
  input  matmul_pkg::addr_t i_addr,
  input  matmul_pkg::row_t  i_wdata,
  input  logic              i_we,
  output matmul_pkg::row_t  o_rdata
);
  import matmul_pkg::*;

  row_t mem [`MM_MEM_DEPTH];

  // registered read, a write to the same address returns the old word
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
    o_rdata <= mem[i_addr];
  end

endmodule

`default_nettype wire

// ==== hw/matrix_store.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module matrix_store (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_host_rd,
  input  logic              i_we_a,
  input  logic              i_we_b,
  input  matmul_pkg::addr_t i_host_addr,
  input  matmul_pkg::row_t  i_host_wdata,
  matmul_ctrl_if.store      ctrl,
  input  matmul_pkg::row_t  i_c_row,
  output matmul_pkg::row_t  o_a_row,
  output matmul_pkg::row_t  o_b_row,
  output matmul_pkg::row_t  o_host_rdata
);
  import matmul_pkg::*;

  addr_t      host_addr_q;
  row_t       host_wdata_q;
  logic [1:0] host_we_q;
  logic       host_rd_q;
  addr_t      eng_addr [2];
  row_t       op_row [2];
  addr_t      c_ram_addr;

  // host port is sampled on one edge and acted on at the next
  always_ff @(posedge clk) begin
    if (reset) begin
      host_addr_q <= '0;
      host_we_q   <= '0;
      host_rd_q   <= 1'b0;
    end else begin
      host_addr_q <= i_host_addr;
      host_we_q   <= {i_we_b, i_we_a};
      host_rd_q   <= i_host_rd;
    end
  end

  always_ff @(posedge clk) begin
    host_wdata_q <= i_host_wdata;
  end

  assign eng_addr[0] = ctrl.a_addr;
  assign eng_addr[1] = ctrl.b_addr;

  // lane 0 is A, lane 1 is B
  for (genvar g = 0; g < 2; g++) begin : g_operand
    addr_t eng_q;
    addr_t ram_addr;
    logic  vld;
    row_t  ram_q;

    // vld lines up with the registered read data
    always_ff @(posedge clk) begin
      if (reset) begin
        eng_q <= addr_t'(`MM_IDLE_ADDR);
        vld   <= 1'b0;
      end else begin
        eng_q <= eng_addr[g];
        vld   <= ctrl.busy && (eng_q != addr_t'(`MM_IDLE_ADDR));
      end
    end

    assign ram_addr = ctrl.busy ? eng_q : host_addr_q;

    matrix_ram u_ram (
      .clk     (clk),
      .i_addr  (ram_addr),
      .i_wdata (host_wdata_q),
      .i_we    (host_we_q[g]),
      .o_rdata (ram_q)
    );

    // empty fetch slots feed zeros so nothing stale reaches the grid
    assign op_row[g] = vld ? ram_q : '0;
  end

  assign o_a_row = op_row[0];
  assign o_b_row = op_row[1];

  // engine writes C during a run, host reads it back afterwards
  assign c_ram_addr = ctrl.busy ? ctrl.c_addr :
                      host_rd_q ? host_addr_q : addr_t'(`MM_IDLE_ADDR);

  matrix_ram u_ram_c (
    .clk     (clk),
    .i_addr  (c_ram_addr),
    .i_wdata (i_c_row),
    .i_we    (ctrl.c_we),
    .o_rdata (o_host_rdata)
  );

  // host writes would land on engine addresses during a run
  a_no_host_write_busy: assert property (
    @(posedge clk) disable iff (reset) (|host_we_q) |-> !ctrl.busy
  );

endmodule

`default_nettype wire

// ==== hw/matmul_sequencer.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module matmul_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_start,
  matmul_ctrl_if.sequencer    ctrl,
  output logic                o_clear,
  output logic [`MM_SIZE-1:0] o_row_capture,
  output logic                o_done
);
  import matmul_pkg::*;

  // write-back begins on the count that captures the last grid row
  localparam int wr_first = `MM_DRAIN_CYCLE + `MM_SIZE - 1;

  cnt_t  cnt;
  addr_t op_addr;
  logic  wr_window;

  // counter freezes at the done count until i_start drops
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      cnt    <= '0;
      o_done <= 1'b0;
    end else if (cnt == cnt_t'(`MM_DONE_CYCLE)) begin
      o_done <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // the idle address is the last word, so the first step wraps to 0
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      op_addr <= addr_t'(`MM_IDLE_ADDR);
    end else if (cnt < cnt_t'(`MM_SIZE)) begin
      op_addr <= op_addr + 1'b1;
    end else begin
      op_addr <= addr_t'(`MM_IDLE_ADDR);
    end
  end

  // A columns and B rows are fetched in lockstep
  assign ctrl.a_addr = op_addr;
  assign ctrl.b_addr = op_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl.busy <= 1'b0;
    end else begin
      ctrl.busy <= i_start;
    end
  end

  // accumulators and skew lines are held at zero between runs
  assign o_clear = !ctrl.busy;

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_capture
    assign o_row_capture[r] = (cnt == cnt_t'(`MM_DRAIN_CYCLE + r));
  end

  assign wr_window = (cnt >= cnt_t'(wr_first)) && (cnt < cnt_t'(wr_first + `MM_SIZE));

  // one C column per clock, addresses 0 upwards
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      ctrl.c_we   <= 1'b0;
      ctrl.c_addr <= '0;
    end else begin
      ctrl.c_we   <= wr_window;
      ctrl.c_addr <= ctrl.c_we ? ctrl.c_addr + 1'b1 : '0;
    end
  end

  // the last C column is written before done goes high
  a_done_after_write: assert property (
    @(posedge clk) disable iff (reset) o_done |-> !ctrl.c_we
  );

  // drain registers stop shifting during a capture, so no write may overlap it
  a_capture_outside_write: assert property (
    @(posedge clk) disable iff (reset) (|o_row_capture) |-> !ctrl.c_we
  );

endmodule

`default_nettype wire

// ==== hw/operand_skew.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module operand_skew (
  input  logic             clk,
  input  logic             reset,
  input  logic             i_clear,
  input  matmul_pkg::row_t i_row,
  output matmul_pkg::row_t o_edge
);
  import matmul_pkg::*;

  // lane i passes through i registers
  for (genvar i = 0; i < `MM_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_edge[i] = i_row[i];
    end else begin : g_delay
      elem_t line [i];

      always_ff @(posedge clk) begin
        if (reset || i_clear) begin
          for (int k = 0; k < i; k++) begin
            line[k] <= '0;
          end
        end else begin
          line[0] <= i_row[i];
          for (int k = 1; k < i; k++) begin
            line[k] <= line[k-1];
          end
        end
      end

      assign o_edge[i] = line[i-1];
    end
  end

endmodule

`default_nettype wire

// ==== hw/processing_element.sv ====
`timescale 1ns/1ps
`default_nettype none

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_acc
);
  import matmul_pkg::*;

  elem_t prod;

  // only the low byte of the product is kept
  assign prod = elem_t'(i_a * i_b);

  always_ff @(posedge clk) begin
    if (reset) begin
      o_a   <= '0;
      o_b   <= '0;
      o_acc <= '0;
    end else begin
      // A moves right, B moves down
      o_a   <= i_a;
      o_b   <= i_b;
      // sum wraps modulo 256
      o_acc <= i_clear ? '0 : o_acc + prod;
    end
  end

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module systolic_array (
  input  logic                clk,
  input  logic                reset,
  input  logic                i_clear,
  input  matmul_pkg::row_t    i_a_edge,
  input  matmul_pkg::row_t    i_b_edge,
  input  logic [`MM_SIZE-1:0] i_row_capture,
  output matmul_pkg::row_t    o_c_row
);
  import matmul_pkg::*;

  // outputs on the far right column and bottom row go nowhere
  grid_t a_fwd;
  grid_t b_fwd;
  grid_t acc;

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    row_t drain;

    for (genvar c = 0; c < `MM_SIZE; c++) begin : g_col
      elem_t a_in;
      elem_t b_in;

      if (c == 0) begin : g_a_edge
        assign a_in = i_a_edge[r];
      end else begin : g_a_link
        assign a_in = a_fwd[r][c-1];
      end

      if (r == 0) begin : g_b_edge
        assign b_in = i_b_edge[c];
      end else begin : g_b_link
        assign b_in = b_fwd[r-1][c];
      end

      processing_element u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_in),
        .i_b     (b_in),
        .o_a     (a_fwd[r][c]),
        .o_b     (b_fwd[r][c]),
        .o_acc   (acc[r][c])
      );
    end

    // a captured row waits for the rest of the sweep, so all lanes
    // start shifting together and each output word is one C column
    always_ff @(posedge clk) begin
      if (i_row_capture[r]) begin
        drain <= acc[r];
      end else if (i_row_capture == '0) begin
        drain <= drain >> `MM_DWIDTH;
      end
    end

    assign o_c_row[r] = drain[0];
  end

endmodule

`default_nettype wire

// ==== hw/matmul_top.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module matmul_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_start,
  input  logic              i_host_rd,
  input  logic              i_we_a,
  input  logic              i_we_b,
  input  matmul_pkg::addr_t i_host_addr,
  input  matmul_pkg::row_t  i_host_wdata,
  output matmul_pkg::row_t  o_host_rdata,
  output logic              o_done
);
  import matmul_pkg::*;

  row_t                a_row;
  row_t                b_row;
  row_t                a_edge;
  row_t                b_edge;
  row_t                c_row;
  logic                clear;
  logic [`MM_SIZE-1:0] row_capture;

  matmul_ctrl_if u_ctrl_if ();

  matrix_store u_store (
    .clk          (clk),
    .reset        (reset),
    .i_host_rd    (i_host_rd),
    .i_we_a       (i_we_a),
    .i_we_b       (i_we_b),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .ctrl         (u_ctrl_if.store),
    .i_c_row      (c_row),
    .o_a_row      (a_row),
    .o_b_row      (b_row),
    .o_host_rdata (o_host_rdata)
  );

  matmul_sequencer u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .i_start       (i_start),
    .ctrl          (u_ctrl_if.sequencer),
    .o_clear       (clear),
    .o_row_capture (row_capture),
    .o_done        (o_done)
  );

  // A columns enter the left edge, B rows the top edge
  operand_skew u_skew_a (
    .clk     (clk),
    .reset   (reset),
    .i_clear (clear),
    .i_row   (a_row),
    .o_edge  (a_edge)
  );

  operand_skew u_skew_b (
    .clk     (clk),
    .reset   (reset),
    .i_clear (clear),
    .i_row   (b_row),
    .o_edge  (b_edge)
  );

  systolic_array u_array (
    .clk           (clk),
    .reset         (reset),
    .i_clear       (clear),
    .i_a_edge      (a_edge),
    .i_b_edge      (b_edge),
    .i_row_capture (row_capture),
    .o_c_row       (c_row)
  );

endmodule

`default_nettype wire

// ==== verif/tb_matmul.sv ====
`timescale 1ns/1ps
`include "matmul_defs.svh"
`default_nettype none

module tb_matmul;
  import matmul_pkg::*;

  localparam int clk_period     = 4;
  localparam int num_cases      = 3;
  localparam int words_per_case = 3 * `MM_SIZE;
  localparam int done_latency   = 19;

  logic  clk;
  logic  reset;
  logic  i_start;
  logic  i_host_rd;
  logic  i_we_a;
  logic  i_we_b;
  addr_t i_host_addr;
  row_t  i_host_wdata;
  row_t  o_host_rdata;
  logic  o_done;

  // per case: A columns, B rows, expected C columns
  row_t        golden [num_cases * words_per_case];

  matmul_top u_matmul_top (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .i_host_rd    (i_host_rd),
    .i_we_a       (i_we_a),
    .i_we_b       (i_we_b),
    .i_host_addr  (i_host_addr),
    .i_host_wdata (i_host_wdata),
    .o_host_rdata (o_host_rdata),
    .o_done       (o_done)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_failure(input string msg);
    $display("%s at time %0t", msg, $time);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // 0 to 3 idle cycles between host accesses
  task automatic idle_gap();
    int unsigned gap;
    gap = $urandom % 4;
    repeat (gap) @(negedge clk);
  endtask

  task automatic write_word(input logic to_b, input int addr, input row_t data);
    @(negedge clk);
    i_host_addr  = addr_t'(addr);
    i_host_wdata = data;
    i_we_a       = !to_b;
    i_we_b       = to_b;
    @(negedge clk);
    i_we_a = 1'b0;
    i_we_b = 1'b0;
  endtask

  task automatic load_case(input int base);
    for (int k = 0; k < `MM_SIZE; k++) begin
      idle_gap();
      write_word(1'b0, k, golden[base + k]);
      idle_gap();
      write_word(1'b1, k, golden[base + `MM_SIZE + k]);
    end
  endtask

  // start a run, time o_done, then release start
  task automatic run_engine();
    int waited;
    @(negedge clk);
    check_value("o_done", 32'd0, o_done);
    i_start = 1'b1;
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (o_done !== 1'b1 && waited < 2 * done_latency);
    if (o_done !== 1'b1) begin
      report_failure("o_done did not rise after i_start went high");
    end
    check_value("o_done latency", done_latency, waited);
    // start held past done just idles
    @(negedge clk);
    check_value("o_done", 32'd1, o_done);
    i_start = 1'b0;
    @(negedge clk);
    check_value("o_done", 32'd0, o_done);
  endtask

  // read data shows up two clocks after the address is sampled
  task automatic read_case(input int base);
    int order [4];
    order = '{2, 0, 3, 1};
    for (int n = 0; n < `MM_SIZE; n++) begin
      idle_gap();
      @(negedge clk);
      i_host_addr = addr_t'(order[n]);
      i_host_rd   = 1'b1;
      @(negedge clk);
      i_host_rd = 1'b0;
      @(negedge clk);
      check_value($sformatf("o_host_rdata[C%0d]", order[n]),
                  golden[base + 2 * `MM_SIZE + order[n]], o_host_rdata);
    end
  endtask

  initial begin
    #(num_cases * 200 * clk_period);
    report_failure("watchdog expired before all test cases finished");
  end

  initial begin
    void'($urandom(32'h5577743c));
    clk          = 1'b0;
    reset        = 1'b1;
    i_start      = 1'b0;
    i_host_rd    = 1'b0;
    i_we_a       = 1'b0;
    i_we_b       = 1'b0;
    i_host_addr  = '0;
    i_host_wdata = '0;
    $readmemh("verif/matmul_golden.txt", golden);
    if ($isunknown(golden[num_cases * words_per_case - 1])) begin
      report_failure("golden file is missing or too short");
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("o_done", 32'd0, o_done);
    // cases run back to back, so each one also proves the clear
    for (int c = 0; c < num_cases; c++) begin
      load_case(c * words_per_case);
      repeat (2) @(negedge clk);
      run_engine();
      read_case(c * words_per_case);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/matmul_golden.txt ====
// per case 12 words of 32 bits, lane 0 in the low byte
// A columns 0..3, then B rows 0..3, then expected C columns 0..3
// case 1: identity B, so C equals A
41312111
42322212
43332313
44342414
00000001
00000100
00010000
01000000
41312111
42322212
43332313
44342414
// case 2: small positive values
04000201
00030102
01020100
02010003
01010002
02000301
01040100
00010203
0e06050d
050d040c
0a090604
05080505
// case 3: large values, products and sums wrap modulo 256
c81080ff
642001ff
023010ff
fe4002ff
801002ff
1008ff03
20ff0411
ff018005
7cc09de8
34c03f7b
9c10fae8
82c00e51

// ==== sim.f ====
+incdir+hw
hw/matmul_pkg.sv
hw/matmul_ctrl_if.sv
hw/matrix_ram.sv
hw/matrix_store.sv
hw/matmul_sequencer.sv
hw/operand_skew.sv
hw/processing_element.sv
hw/systolic_array.sv
hw/matmul_top.sv
verif/tb_matmul.sv

// ==== Bender.yml ====
package:
  name: matmul

sources:
  - include_dirs:
      - hw
    files:
      - hw/matmul_pkg.sv
      - hw/matmul_ctrl_if.sv
      - hw/matrix_ram.sv
      - hw/matrix_store.sv
      - hw/matmul_sequencer.sv
      - hw/operand_skew.sv
      - hw/processing_element.sv
      - hw/systolic_array.sv
      - hw/matmul_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/tb_matmul.sv
